//--- rtl/dll_rx_pkg.sv
// Shared types for the PCIe data link layer receive path.
// Holds the TLP opcode and credit class encodings, the beat and verdict
// structs passed between stages, and the credit counter layout.
`default_nettype none

package dll_rx_pkg;

  // fmt/type byte of TLP dword 0
  typedef enum logic [7:0] {
    MRd32    = 8'h00,
    MRdLk    = 8'h01,
    IORd     = 8'h02,
    CfgRd0   = 8'h04,
    CfgRd1   = 8'h05,
    Cpl      = 8'h0A,
    CplLk    = 8'h0B,
    MRd64    = 8'h20,
    Msg      = 8'h30,
    MWr32    = 8'h40,
    IOWr     = 8'h42,
    CfgWr0   = 8'h44,
    CfgWr1   = 8'h45,
    CplD     = 8'h4A,
    CplDLk   = 8'h4B,
    FetchAdd = 8'h4C,
    Swap     = 8'h4D,
    Cas      = 8'h4E,
    MWr64    = 8'h60,
    MsgD     = 8'h70
  } tlp_fmt_type_e;

  typedef enum logic [2:0] {
    CLS_NONE,
    CLS_PH,
    CLS_PD,
    CLS_NPH,
    CLS_NPD,
    CLS_CPLH,
    CLS_CPLD
  } tlp_class_e;

  typedef enum logic [1:0] {
    BK_SEQ,
    BK_HDR0,
    BK_BODY,
    BK_LCRC
  } beat_kind_e;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  keep;
    beat_kind_e  kind;
  } rx_beat_t;

  typedef struct packed {
    logic [15:0] seq;
    tlp_class_e  cls;
    logic [9:0]  length_dw;
  } frame_info_t;

  typedef struct packed {
    frame_info_t info;
    logic        crc_ok;
  } frame_verdict_t;

  localparam int HDR_CRED_W  = 8;
  localparam int DATA_CRED_W = 12;

  // consumed credits per class
  typedef struct packed {
    logic [HDR_CRED_W-1:0]  ph;
    logic [HDR_CRED_W-1:0]  nph;
    logic [HDR_CRED_W-1:0]  cplh;
    logic [DATA_CRED_W-1:0] pd;
    logic [DATA_CRED_W-1:0] npd;
    logic [DATA_CRED_W-1:0] cpld;
  } credit_count_t;

  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

//--- rtl/dll_rx_frame_parser.sv
// Input stage of the DLL receive path.
// Registers each accepted beat, tags it as sequence, header, body or LCRC,
// and keeps the sequence number and class/length of the current frame.
`default_nettype none

module dll_rx_frame_parser (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [31:0]             s_tdata_i,
  input  logic [3:0]              s_tkeep_i,
  input  logic                    s_tvalid_i,
  input  logic                    s_tlast_i,
  output logic                    s_tready_o,
  input  logic                    room_i,
  input  logic                    busy_i,
  output dll_rx_pkg::rx_beat_t    beat_o,
  output logic                    beat_valid_o,
  output dll_rx_pkg::frame_info_t info_o
);

  typedef enum logic [1:0] {
    PS_SEQ,
    PS_HDR,
    PS_BODY
  } parse_state_e;

  parse_state_e           state_q;
  parse_state_e           state_next_c;
  dll_rx_pkg::beat_kind_e kind_c;
  logic                   accept_c;

  function automatic dll_rx_pkg::tlp_class_e decode_class(input logic [7:0] fmt_type);
    case (fmt_type)
      dll_rx_pkg::MRd32, dll_rx_pkg::MRd64, dll_rx_pkg::MRdLk,
      dll_rx_pkg::IORd, dll_rx_pkg::CfgRd0, dll_rx_pkg::CfgRd1:
        decode_class = dll_rx_pkg::CLS_NPH;
      dll_rx_pkg::IOWr, dll_rx_pkg::CfgWr0, dll_rx_pkg::CfgWr1,
      dll_rx_pkg::FetchAdd, dll_rx_pkg::Swap, dll_rx_pkg::Cas:
        decode_class = dll_rx_pkg::CLS_NPD;
      dll_rx_pkg::MWr32, dll_rx_pkg::MWr64, dll_rx_pkg::MsgD:
        decode_class = dll_rx_pkg::CLS_PD;
      dll_rx_pkg::Msg:
        decode_class = dll_rx_pkg::CLS_PH;
      dll_rx_pkg::Cpl, dll_rx_pkg::CplLk:
        decode_class = dll_rx_pkg::CLS_CPLH;
      dll_rx_pkg::CplD, dll_rx_pkg::CplDLk:
        decode_class = dll_rx_pkg::CLS_CPLD;
      default:
        decode_class = dll_rx_pkg::CLS_NONE;
    endcase
  endfunction

  assign accept_c = s_tvalid_i && s_tready_o;

  // last beat of a frame is always the LCRC word
  always_comb begin
    state_next_c = state_q;
    kind_c       = dll_rx_pkg::BK_BODY;
    if (s_tlast_i) begin
      kind_c       = dll_rx_pkg::BK_LCRC;
      state_next_c = PS_SEQ;
    end else if (state_q == PS_SEQ) begin
      kind_c       = dll_rx_pkg::BK_SEQ;
      state_next_c = PS_HDR;
    end else if (state_q == PS_HDR) begin
      kind_c       = dll_rx_pkg::BK_HDR0;
      state_next_c = PS_BODY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= PS_SEQ;
      s_tready_o   <= 1'b0;
      beat_valid_o <= 1'b0;
    end else begin
      s_tready_o   <= room_i && !busy_i;
      beat_valid_o <= accept_c;
      if (accept_c) begin
        state_q <= state_next_c;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_c) begin
      beat_o.data <= s_tdata_i;
      beat_o.keep <= s_tkeep_i;
      beat_o.kind <= kind_c;
      if (kind_c == dll_rx_pkg::BK_SEQ) begin
        info_o.seq <= s_tdata_i[15:0];
      end
      if (kind_c == dll_rx_pkg::BK_HDR0) begin
        info_o.cls       <= decode_class(s_tdata_i[7:0]);
        // length[9:8] in byte 2, length[7:0] in byte 3
        info_o.length_dw <= {s_tdata_i[17:16], s_tdata_i[31:24]};
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/lcrc_checker.sv
// LCRC check stage.
// Runs a reflected CRC-32 over every beat of a frame up to the LCRC word,
// forwards TLP dwords to the frame FIFO and issues one verdict per frame.
`default_nettype none

module lcrc_checker (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  dll_rx_pkg::rx_beat_t       beat_i,
  input  logic                       beat_valid_i,
  input  dll_rx_pkg::frame_info_t    info_i,
  output dll_rx_pkg::rx_beat_t       wr_beat_o,
  output logic                       wr_valid_o,
  output dll_rx_pkg::frame_verdict_t verdict_o,
  output logic                       verdict_valid_o
);

  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

  logic [31:0]          crc_q;
  dll_rx_pkg::rx_beat_t held_q;
  logic                 held_valid_q;
  logic                 tlp_beat_c;
  logic                 lcrc_beat_c;

  // byte 0 first, lsb first within each byte
  function automatic logic [31:0] crc_word(input logic [31:0] crc_in, input logic [31:0] data);
    logic [31:0] crc;
    crc = crc_in;
    for (int b = 0; b < 4; b++) begin
      crc = crc ^ {24'd0, data[8*b +: 8]};
      for (int i = 0; i < 8; i++) begin
        crc = crc[0] ? ((crc >> 1) ^ CRC_POLY) : (crc >> 1);
      end
    end
    return crc;
  endfunction

  assign tlp_beat_c  = beat_i.kind inside {dll_rx_pkg::BK_HDR0, dll_rx_pkg::BK_BODY};
  assign lcrc_beat_c = beat_i.kind == dll_rx_pkg::BK_LCRC;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      crc_q           <= dll_rx_pkg::CRC_INIT;
      held_valid_q    <= 1'b0;
      wr_valid_o      <= 1'b0;
      verdict_valid_o <= 1'b0;
    end else begin
      wr_valid_o      <= 1'b0;
      verdict_valid_o <= 1'b0;
      if (beat_valid_i) begin
        // a held dword is released by the next TLP dword or by the LCRC word
        wr_valid_o <= held_valid_q && (tlp_beat_c || lcrc_beat_c);
        if (lcrc_beat_c) begin
          crc_q           <= dll_rx_pkg::CRC_INIT;
          held_valid_q    <= 1'b0;
          verdict_valid_o <= 1'b1;
        end else begin
          crc_q <= crc_word(crc_q, beat_i.data);
          if (tlp_beat_c) begin
            held_valid_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      if (tlp_beat_c) begin
        held_q <= beat_i;
      end
      wr_beat_o.data <= held_q.data;
      wr_beat_o.keep <= held_q.keep;
      // end of frame marker for the FIFO
      wr_beat_o.kind <= lcrc_beat_c ? dll_rx_pkg::BK_LCRC : held_q.kind;
      if (lcrc_beat_c) begin
        verdict_o.info   <= info_i;
        verdict_o.crc_ok <= (~crc_q) == beat_i.data;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/seq_credit_tracker.sv
// Frame acceptance and flow control bookkeeping.
// Judges each frame on LCRC and sequence number, commits or drops it in the
// FIFO, counts consumed credits and runs the flow-control request handshake.
`default_nettype none

module seq_credit_tracker #(
  parameter int MAX_PAYLOAD_SIZE = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  dll_rx_pkg::frame_verdict_t verdict_i,
  input  logic                       verdict_valid_i,
  input  logic                       start_flow_control_ack_i,
  output logic                       commit_o,
  output logic                       drop_o,
  output logic                       busy_o,
  output logic                       start_flow_control_o,
  output logic                       tlp_nullified_o,
  output logic [15:0]                next_transmit_seq_o,
  output dll_rx_pkg::credit_count_t  fc_credits_o
);

  localparam logic [dll_rx_pkg::HDR_CRED_W-1:0] HDR_INIT =
    dll_rx_pkg::HDR_CRED_W'(1);
  localparam logic [dll_rx_pkg::DATA_CRED_W-1:0] DATA_INIT =
    dll_rx_pkg::DATA_CRED_W'(MAX_PAYLOAD_SIZE / 16);

  logic [15:0]                        expected_seq_q;
  logic                               good_c;
  logic                               good_q;
  logic [7:0]                         quarter_c;
  logic [dll_rx_pkg::DATA_CRED_W-1:0] data_inc_c;
  dll_rx_pkg::credit_count_t          credits_c;

  assign good_c   = verdict_i.crc_ok && (verdict_i.info.seq == expected_seq_q);
  assign commit_o = verdict_valid_i && good_c;
  assign drop_o   = verdict_valid_i && !good_c;
  // input stalls from the verdict until the request is acknowledged
  assign busy_o   = verdict_valid_i || start_flow_control_o;

  assign quarter_c = verdict_i.info.length_dw[9:2];

  always_comb begin
    data_inc_c      = '0;
    data_inc_c[7:0] = (quarter_c == '0) ? 8'd1 : quarter_c;
    credits_c       = fc_credits_o;
    case (verdict_i.info.cls)
      dll_rx_pkg::CLS_PH: begin
        credits_c.ph = fc_credits_o.ph + 1'b1;
      end
      dll_rx_pkg::CLS_PD: begin
        credits_c.ph = fc_credits_o.ph + 1'b1;
        credits_c.pd = fc_credits_o.pd + data_inc_c;
      end
      dll_rx_pkg::CLS_NPH: begin
        credits_c.nph = fc_credits_o.nph + 1'b1;
      end
      dll_rx_pkg::CLS_NPD: begin
        credits_c.nph = fc_credits_o.nph + 1'b1;
        credits_c.npd = fc_credits_o.npd + data_inc_c;
      end
      dll_rx_pkg::CLS_CPLH: begin
        credits_c.cplh = fc_credits_o.cplh + 1'b1;
      end
      dll_rx_pkg::CLS_CPLD: begin
        credits_c.cplh = fc_credits_o.cplh + 1'b1;
        credits_c.cpld = fc_credits_o.cpld + data_inc_c;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      expected_seq_q       <= '0;
      good_q               <= 1'b0;
      start_flow_control_o <= 1'b0;
      tlp_nullified_o      <= 1'b0;
      next_transmit_seq_o  <= '0;
      fc_credits_o         <= '{ph: HDR_INIT, nph: HDR_INIT, cplh: HDR_INIT,
                                pd: DATA_INIT, npd: DATA_INIT, cpld: DATA_INIT};
    end else if (verdict_valid_i) begin
      start_flow_control_o <= 1'b1;
      tlp_nullified_o      <= !good_c;
      next_transmit_seq_o  <= verdict_i.info.seq;
      good_q               <= good_c;
      if (good_c) begin
        fc_credits_o <= credits_c;
      end
    end else if (start_flow_control_o && start_flow_control_ack_i) begin
      start_flow_control_o <= 1'b0;
      // sequence only moves on once the link partner has been told
      if (good_q) begin
        expected_seq_q <= expected_seq_q + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/tlp_frame_fifo.sv
// Frame FIFO between the DLL checks and the transaction layer.
// Dwords are written speculatively, made visible on commit and discarded on
// drop, so only frames that passed both checks reach the m_ stream.
// FIFO_DEPTH must be a power of two.
`default_nettype none

module tlp_frame_fifo #(
  parameter int FIFO_DEPTH = 512
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  dll_rx_pkg::rx_beat_t wr_beat_i,
  input  logic                 wr_valid_i,
  input  logic                 commit_i,
  input  logic                 drop_i,
  output logic                 room_o,
  output logic [31:0]          m_tdata_o,
  output logic [3:0]           m_tkeep_o,
  output logic                 m_tvalid_o,
  output logic                 m_tlast_o,
  input  logic                 m_tready_i
);

  localparam int AW = $clog2(FIFO_DEPTH);

  dll_rx_pkg::rx_beat_t mem_q [FIFO_DEPTH];
  dll_rx_pkg::rx_beat_t out_q;

  logic [AW:0]   rd_ptr_q;
  logic [AW:0]   commit_ptr_q;
  logic [AW:0]   spec_ptr_q;
  logic [AW:0]   spec_next_c;
  logic [AW+1:0] used_c;
  logic          rd_en_c;

  assign spec_next_c = spec_ptr_q + {{AW{1'b0}}, wr_valid_i};

  // count the write of this cycle so the margin covers parser and checker
  assign used_c = {1'b0, spec_ptr_q - rd_ptr_q} + {{(AW + 1){1'b0}}, wr_valid_i};
  assign room_o = used_c <= (AW + 2)'(FIFO_DEPTH - 4);

  // refill output register when empty or being drained
  assign rd_en_c = (rd_ptr_q != commit_ptr_q) && (!m_tvalid_o || m_tready_i);

  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mem_q[spec_ptr_q[AW-1:0]] <= wr_beat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_c) begin
      out_q <= mem_q[rd_ptr_q[AW-1:0]];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q     <= '0;
      commit_ptr_q <= '0;
      spec_ptr_q   <= '0;
      m_tvalid_o   <= 1'b0;
    end else begin
      // rollback also throws away a write landing in the same cycle
      if (drop_i) begin
        spec_ptr_q <= commit_ptr_q;
      end else begin
        spec_ptr_q <= spec_next_c;
      end
      if (commit_i) begin
        commit_ptr_q <= spec_next_c;
      end
      if (rd_en_c) begin
        rd_ptr_q   <= rd_ptr_q + 1'b1;
        m_tvalid_o <= 1'b1;
      end else if (m_tready_i) begin
        m_tvalid_o <= 1'b0;
      end
    end
  end

  assign m_tdata_o = out_q.data;
  assign m_tkeep_o = out_q.keep;
  assign m_tlast_o = out_q.kind == dll_rx_pkg::BK_LCRC;

endmodule

`default_nettype wire

//--- rtl/dll_rx_top.sv
// Receive side of the PCIe data link layer.
// Takes framed beats (sequence word, TLP dwords, LCRC word) on the s_ stream
// and delivers checked TLPs on the m_ stream, with credit and FC status.
`default_nettype none

module dll_rx_top #(
  parameter int MAX_PAYLOAD_SIZE = 256,
  parameter int FIFO_DEPTH       = 512
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [31:0]               s_tdata_i,
  input  logic [3:0]                s_tkeep_i,
  input  logic                      s_tvalid_i,
  input  logic                      s_tlast_i,
  output logic                      s_tready_o,
  output logic [31:0]               m_tdata_o,
  output logic [3:0]                m_tkeep_o,
  output logic                      m_tvalid_o,
  output logic                      m_tlast_o,
  input  logic                      m_tready_i,
  output logic                      start_flow_control_o,
  input  logic                      start_flow_control_ack_i,
  output logic [15:0]               next_transmit_seq_o,
  output logic                      tlp_nullified_o,
  output dll_rx_pkg::credit_count_t fc_credits_o
);

  dll_rx_pkg::rx_beat_t       beat;
  logic                       beat_valid;
  dll_rx_pkg::frame_info_t    info;
  dll_rx_pkg::rx_beat_t       wr_beat;
  logic                       wr_valid;
  dll_rx_pkg::frame_verdict_t verdict;
  logic                       verdict_valid;
  logic                       commit;
  logic                       drop;
  logic                       room;
  logic                       busy;

  dll_rx_frame_parser parser_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .s_tdata_i    (s_tdata_i),
    .s_tkeep_i    (s_tkeep_i),
    .s_tvalid_i   (s_tvalid_i),
    .s_tlast_i    (s_tlast_i),
    .s_tready_o   (s_tready_o),
    .room_i       (room),
    .busy_i       (busy),
    .beat_o       (beat),
    .beat_valid_o (beat_valid),
    .info_o       (info)
  );

  lcrc_checker checker_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .beat_i          (beat),
    .beat_valid_i    (beat_valid),
    .info_i          (info),
    .wr_beat_o       (wr_beat),
    .wr_valid_o      (wr_valid),
    .verdict_o       (verdict),
    .verdict_valid_o (verdict_valid)
  );

  seq_credit_tracker #(
    .MAX_PAYLOAD_SIZE (MAX_PAYLOAD_SIZE)
  ) tracker_i (
    .clk_i                    (clk_i),
    .rst_i                    (rst_i),
    .verdict_i                (verdict),
    .verdict_valid_i          (verdict_valid),
    .start_flow_control_ack_i (start_flow_control_ack_i),
    .commit_o                 (commit),
    .drop_o                   (drop),
    .busy_o                   (busy),
    .start_flow_control_o     (start_flow_control_o),
    .tlp_nullified_o          (tlp_nullified_o),
    .next_transmit_seq_o      (next_transmit_seq_o),
    .fc_credits_o             (fc_credits_o)
  );

  tlp_frame_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_beat_i  (wr_beat),
    .wr_valid_i (wr_valid),
    .commit_i   (commit),
    .drop_i     (drop),
    .room_o     (room),
    .m_tdata_o  (m_tdata_o),
    .m_tkeep_o  (m_tkeep_o),
    .m_tvalid_o (m_tvalid_o),
    .m_tlast_o  (m_tlast_o),
    .m_tready_i (m_tready_i)
  );

endmodule

`default_nettype wire

//--- test/tlp_model.svh
// Reference model for the DLL receive testbench.
// Bit-serial CRC-32, TLP credit classes, credit counting and a frame
// builder; included inside the testbench module.
`ifndef TLP_MODEL_SVH
`define TLP_MODEL_SVH

// reflected CRC-32, one bit at a time, bit 0 of byte 0 first
function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [31:0] word);
  logic [31:0] c;
  logic        fb;
  c = crc;
  for (int i = 0; i < 32; i++) begin
    fb = c[0] ^ word[i];
    c  = {1'b0, c[31:1]};
    if (fb) begin
      c = c ^ 32'hEDB8_8320;
    end
  end
  return c;
endfunction

// PCIe flow-control class of a fmt/type byte
function automatic dll_rx_pkg::tlp_class_e class_of(input logic [7:0] fmt_type);
  case (fmt_type)
    8'h00, 8'h01, 8'h02, 8'h04, 8'h05, 8'h20:
      return dll_rx_pkg::CLS_NPH;
    8'h42, 8'h44, 8'h45, 8'h4C, 8'h4D, 8'h4E:
      return dll_rx_pkg::CLS_NPD;
    8'h40, 8'h60, 8'h70:
      return dll_rx_pkg::CLS_PD;
    8'h30:
      return dll_rx_pkg::CLS_PH;
    8'h0A, 8'h0B:
      return dll_rx_pkg::CLS_CPLH;
    8'h4A, 8'h4B:
      return dll_rx_pkg::CLS_CPLD;
    default:
      return dll_rx_pkg::CLS_NONE;
  endcase
endfunction

// 3-dword header plus payload for the data classes
function automatic int tlp_dwords(input logic [7:0] fmt_type, input logic [9:0] len);
  dll_rx_pkg::tlp_class_e cls;
  cls = class_of(fmt_type);
  if (cls inside {dll_rx_pkg::CLS_PD, dll_rx_pkg::CLS_NPD, dll_rx_pkg::CLS_CPLD}) begin
    return 3 + int'(len);
  end
  return 3;
endfunction

function automatic dll_rx_pkg::credit_count_t credits_after(
  input dll_rx_pkg::credit_count_t c, input logic [7:0] fmt_type, input logic [9:0] len);
  dll_rx_pkg::credit_count_t n;
  int unsigned               data;
  n    = c;
  data = (len / 4 == 0) ? 1 : len / 4;
  case (class_of(fmt_type))
    dll_rx_pkg::CLS_PH: n.ph = n.ph + 8'd1;
    dll_rx_pkg::CLS_NPH: n.nph = n.nph + 8'd1;
    dll_rx_pkg::CLS_CPLH: n.cplh = n.cplh + 8'd1;
    dll_rx_pkg::CLS_PD: begin
      n.ph = n.ph + 8'd1;
      n.pd = n.pd + 12'(data);
    end
    dll_rx_pkg::CLS_NPD: begin
      n.nph = n.nph + 8'd1;
      n.npd = n.npd + 12'(data);
    end
    dll_rx_pkg::CLS_CPLD: begin
      n.cplh = n.cplh + 8'd1;
      n.cpld = n.cpld + 12'(data);
    end
    default: begin
    end
  endcase
  return n;
endfunction

// beats as {keep, data}: sequence word, TLP dwords, LCRC word
task automatic build_frame(input logic [15:0] seq, input logic [7:0] fmt_type,
                           input logic [9:0] len, input bit bad_crc,
                           output logic [35:0] beats[$]);
  logic [31:0] crc;
  logic [31:0] word;
  beats = {};
  word  = {16'($urandom), seq};
  crc   = crc32_step(32'hFFFF_FFFF, word);
  beats.push_back({4'hF, word});
  for (int i = 0; i < tlp_dwords(fmt_type, len); i++) begin
    word = $urandom;
    if (i == 0) begin
      word = {len[7:0], 6'd0, len[9:8], 8'($urandom), fmt_type};
    end
    crc = crc32_step(crc, word);
    beats.push_back({4'($urandom_range(1, 15)), word});
  end
  word = ~crc;
  if (bad_crc) begin
    word = word ^ 32'h0001_0000;
  end
  beats.push_back({4'hF, word});
endtask

`endif

//--- test/tb_dll_rx.sv
// Testbench for the DLL receive path.
// Sends framed TLPs with good and bad LCRC and sequence numbers, checks the
// m_ stream against a queue of expected words and the credit/sequence status.
`default_nettype none

module tb_dll_rx;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MPS   = 256;
  localparam int DEPTH = 128;

  logic                      clk_i = 1'b0;
  logic                      rst_i;
  logic [31:0]               s_tdata_i;
  logic [3:0]                s_tkeep_i;
  logic                      s_tvalid_i;
  logic                      s_tlast_i;
  logic                      s_tready_o;
  logic [31:0]               m_tdata_o;
  logic [3:0]                m_tkeep_o;
  logic                      m_tvalid_o;
  logic                      m_tlast_o;
  logic                      m_tready_i;
  logic                      start_flow_control_o;
  logic                      start_flow_control_ack_i;
  logic [15:0]               next_transmit_seq_o;
  logic                      tlp_nullified_o;
  dll_rx_pkg::credit_count_t fc_credits_o;

  // {last, keep, data} of words from frames the model accepts
  logic [36:0]               expect_q[$];
  logic [7:0]                plan_fmt[$];
  logic [9:0]                plan_len[$];
  int                        plan_err[$];
  int                        total_beats = 0;
  int                        cycle_limit = 0;
  int                        cycle_count = 0;
  int                        ack_wait = 0;
  logic [15:0]               exp_seq;
  dll_rx_pkg::credit_count_t exp_credits;
  logic                      ready_random;
  logic                      sfc_prev = 1'b0;
  logic                      ack_prev = 1'b0;

  `include "tlp_model.svh"

  dll_rx_top #(
    .MAX_PAYLOAD_SIZE (MPS),
    .FIFO_DEPTH       (DEPTH)
  ) dut_i (
    .clk_i                    (clk_i),
    .rst_i                    (rst_i),
    .s_tdata_i                (s_tdata_i),
    .s_tkeep_i                (s_tkeep_i),
    .s_tvalid_i               (s_tvalid_i),
    .s_tlast_i                (s_tlast_i),
    .s_tready_o               (s_tready_o),
    .m_tdata_o                (m_tdata_o),
    .m_tkeep_o                (m_tkeep_o),
    .m_tvalid_o               (m_tvalid_o),
    .m_tlast_o                (m_tlast_o),
    .m_tready_i               (m_tready_i),
    .start_flow_control_o     (start_flow_control_o),
    .start_flow_control_ack_i (start_flow_control_ack_i),
    .next_transmit_seq_o      (next_transmit_seq_o),
    .tlp_nullified_o          (tlp_nullified_o),
    .fc_credits_o             (fc_credits_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic stop_with(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
      stop_with("run stopped at the first mismatch");
    end
  endtask

  task automatic add_frame(input logic [7:0] fmt, input logic [9:0] len, input int err);
    plan_fmt.push_back(fmt);
    plan_len.push_back(len);
    plan_err.push_back(err);
    total_beats += 2 + tlp_dwords(fmt, len);
  endtask

  // err 1 corrupts the LCRC, err 2 sends a wrong sequence number
  task automatic run_frame(input int idx);
    logic [35:0] beats[$];
    logic [15:0] seq;
    bit          good;
    good = plan_err[idx] == 0;
    seq  = (plan_err[idx] == 2) ? exp_seq + 16'd9 : exp_seq;
    build_frame(seq, plan_fmt[idx], plan_len[idx], plan_err[idx] == 1, beats);
    if (good) begin
      for (int i = 1; i < beats.size() - 1; i++) begin
        expect_q.push_back({i == beats.size() - 2, beats[i]});
      end
      exp_credits = credits_after(exp_credits, plan_fmt[idx], plan_len[idx]);
      exp_seq     = exp_seq + 16'd1;
    end
    for (int i = 0; i < beats.size(); i++) begin
      if ($urandom_range(0, 7) == 0) begin
        s_tvalid_i <= 1'b0;
        @(posedge clk_i);
      end
      s_tdata_i  <= beats[i][31:0];
      s_tkeep_i  <= beats[i][35:32];
      s_tlast_i  <= i == beats.size() - 1;
      s_tvalid_i <= 1'b1;
      @(posedge clk_i);
      while (!s_tready_o) begin
        @(posedge clk_i);
      end
    end
    s_tvalid_i <= 1'b0;
    // status registers load together with the FC request
    while (!start_flow_control_o) begin
      @(posedge clk_i);
    end
    check_value("next_transmit_seq_o", next_transmit_seq_o, seq);
    check_value("tlp_nullified_o", tlp_nullified_o, !good);
    check_value("fc_credits_o", fc_credits_o, exp_credits);
  endtask

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      stop_with($sformatf("timeout after %0d cycles, %0d words still expected",
                          cycle_count, expect_q.size()));
    end
  end

  // acknowledge each FC request after a random wait
  always @(posedge clk_i) begin
    start_flow_control_ack_i <= 1'b0;
    if (!rst_i && start_flow_control_o && !start_flow_control_ack_i) begin
      if (ack_wait == 0) begin
        start_flow_control_ack_i <= 1'b1;
        ack_wait <= $urandom_range(0, 8);
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  always @(posedge clk_i) begin
    m_tready_i <= !ready_random || ($urandom_range(0, 3) != 0);
  end

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (m_tvalid_o && m_tready_i) begin
        if (expect_q.size() == 0) begin
          stop_with("output word appeared with no good frame waiting for it");
        end else begin
          check_value("m_tdata_o", m_tdata_o, expect_q[0][31:0]);
          check_value("m_tkeep_o", m_tkeep_o, expect_q[0][35:32]);
          check_value("m_tlast_o", m_tlast_o, expect_q[0][36]);
          void'(expect_q.pop_front());
        end
      end
      if (sfc_prev && !ack_prev && !start_flow_control_o) begin
        stop_with("start_flow_control_o dropped without an acknowledge");
      end
      // ready is registered, so it follows a pending request one cycle later
      if (sfc_prev) begin
        check_value("s_tready_o", s_tready_o, 1'b0);
      end
    end
    sfc_prev <= start_flow_control_o;
    ack_prev <= start_flow_control_ack_i;
  end

  initial begin
    logic [7:0] random_ops [8];
    int         n_directed;
    void'($urandom(32'h1d19_838f));
    rst_i                    = 1'b1;
    s_tdata_i                = '0;
    s_tkeep_i                = '0;
    s_tvalid_i               = 1'b0;
    s_tlast_i                = 1'b0;
    m_tready_i               = 1'b1;
    start_flow_control_ack_i = 1'b0;
    ready_random             = 1'b0;
    exp_seq                  = '0;
    exp_credits = '{ph: 8'd1, nph: 8'd1, cplh: 8'd1,
                    pd: 12'(MPS / 16), npd: 12'(MPS / 16), cpld: 12'(MPS / 16)};
    random_ops = '{8'h40, 8'h20, 8'h30, 8'h4C, 8'h0A, 8'h4A, 8'h45, 8'h70};

    add_frame(dll_rx_pkg::MWr32, 10'd1, 0);
    add_frame(dll_rx_pkg::MWr64, 10'd8, 0);
    add_frame(dll_rx_pkg::Msg, 10'd0, 0);
    add_frame(dll_rx_pkg::MsgD, 10'd4, 0);
    add_frame(dll_rx_pkg::MRd32, 10'd16, 0);
    add_frame(dll_rx_pkg::CfgRd0, 10'd1, 0);
    add_frame(dll_rx_pkg::IOWr, 10'd1, 0);
    add_frame(dll_rx_pkg::Cas, 10'd6, 0);
    add_frame(dll_rx_pkg::Cpl, 10'd0, 0);
    add_frame(dll_rx_pkg::CplD, 10'd17, 0);
    add_frame(dll_rx_pkg::CplDLk, 10'd64, 0);
    add_frame(dll_rx_pkg::MWr32, 10'd4, 1);
    add_frame(dll_rx_pkg::CplD, 10'd8, 2);
    add_frame(dll_rx_pkg::CplD, 10'd8, 0);
    n_directed = plan_fmt.size();
    for (int i = 0; i < 16; i++) begin
      add_frame(random_ops[$urandom_range(0, 7)], 10'($urandom_range(1, 40)),
                ($urandom_range(0, 5) == 0) ? $urandom_range(1, 2) : 0);
    end
    cycle_limit = 40 * total_beats;

    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    check_value("s_tready_o", s_tready_o, 1'b0);
    check_value("m_tvalid_o", m_tvalid_o, 1'b0);
    check_value("start_flow_control_o", start_flow_control_o, 1'b0);
    check_value("tlp_nullified_o", tlp_nullified_o, 1'b0);
    check_value("fc_credits_o", fc_credits_o, exp_credits);

    for (int f = 0; f < plan_fmt.size(); f++) begin
      if (f == n_directed) begin
        ready_random <= 1'b1;
      end
      run_frame(f);
    end
    while (expect_q.size() != 0 || start_flow_control_o) begin
      @(posedge clk_i);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+test
rtl/dll_rx_pkg.sv
rtl/dll_rx_frame_parser.sv
rtl/lcrc_checker.sv
rtl/seq_credit_tracker.sv
rtl/tlp_frame_fifo.sv
rtl/dll_rx_top.sv
test/tb_dll_rx.sv

//--- run_sim.sh
#!/bin/sh
# Compiles the DLL receive design and testbench with Verilator, runs the
# simulation and decides pass or fail from the log.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_dll_rx \
  --Mdir "$BUILD_DIR" \
  -f compile.f

"$BUILD_DIR/Vtb_dll_rx" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "TEST OK" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
